// ==== issue_params.svh ====
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// issue queue depth and its pointer width
`define ISSUE_QUEUE_SIZE 32
`define ISSUE_QUEUE_WIDTH 5

// architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// datapath width
`define DATA_W 32

`endif

// ==== issue_pkg.sv ====
`include "issue_params.svh"

package issue_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation classes seen by the issue stage
    typedef enum logic [3:0] {
        ALU,
        LOAD,
        STORE,
        BRANCH,
        JUMP,
        MULT,
        MULTU,
        DIV,
        DIVU,
        MFHI,
        MFLO,
        MTHI,
        MTLO,
        SYSCALL,
        ERET
    } op_t;

    typedef struct packed {
        op_t  op;
        logic regwrite;
        logic branch;
        logic jump;
        logic hiwrite;
        logic lowrite;
        logic hitoreg;
        logic lotoreg;
        // SYSCALL and ERET
        logic exception;
    } ctl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     raw_instr;
        word_t     imm;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t rdst;
        ctl_t      ctl;
    } decode_data_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     raw_instr;
        word_t     imm;
        reg_addr_t rdst;
        ctl_t      ctl;
        logic      is_slot;
        word_t     rd1;
        word_t     rd2;
    } issue_data_t;

    typedef struct packed {
        reg_addr_t ra1;
        reg_addr_t ra2;
    } bypass_req_t;

    typedef struct packed {
        logic  ready;
        logic  bypass;
        word_t data;
    } bypass_out_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rdst;
        word_t     data;
    } wb_port_t;

endpackage

// ==== issue_properties.sv ====
`timescale 1ns/10ps

module issue_properties
    import issue_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        flush,
    input issue_data_t dataI [1:0],
    input logic        overflow
);

    int fail_count = 0;

    // o is the older instruction in slot 1, y the younger in slot 0
    function automatic logic pair_illegal(issue_data_t o, issue_data_t y);
        logic o_bj;
        logic reads_dst;
        logic md_pair;
        logic hilo;
        o_bj      = o.ctl.branch | o.ctl.jump;
        reads_dst = o.ctl.regwrite && !o_bj
                 && (y.raw_instr[25:21] == o.rdst || y.raw_instr[20:16] == o.rdst);
        md_pair   = (o.ctl.op inside {MULT, MULTU, DIV, DIVU})
                 && (y.ctl.op inside {MULT, MULTU, DIV, DIVU});
        hilo      = (o.ctl.hiwrite && y.ctl.hitoreg) || (o.ctl.lowrite && y.ctl.lotoreg);
        return reads_dst || md_pair || hilo || y.ctl.branch || y.ctl.jump || o.ctl.exception;
    endfunction

    a_reset_idle: assert property (@(posedge clk)
        $fell(reset) |-> !dataI[1].valid && !dataI[0].valid && !overflow)
    else begin
        fail_count++;
        $error("FAIL %0t: issue or overflow in the first cycle after reset", $time);
    end

    a_slot0_needs_slot1: assert property (@(posedge clk) disable iff (reset)
        dataI[0].valid |-> dataI[1].valid)
    else begin
        fail_count++;
        $error("FAIL %0t: slot 0 issued without slot 1", $time);
    end

    a_stall_blocks: assert property (@(posedge clk) disable iff (reset)
        stall |-> !dataI[1].valid && !dataI[0].valid)
    else begin
        fail_count++;
        $error("FAIL %0t: issue while stalled", $time);
    end

    a_flush_blocks: assert property (@(posedge clk) disable iff (reset)
        flush |-> !dataI[1].valid && !dataI[0].valid)
    else begin
        fail_count++;
        $error("FAIL %0t: issue in the flush cycle", $time);
    end

    a_pair_legal: assert property (@(posedge clk) disable iff (reset)
        dataI[0].valid |-> !pair_illegal(dataI[1], dataI[0]))
    else begin
        fail_count++;
        $error("FAIL %0t: illegal pair %h / %h", $time, dataI[1].pc, dataI[0].pc);
    end

    // branch or jump always leaves with its delay slot
    a_delay_slot: assert property (@(posedge clk) disable iff (reset)
        dataI[1].valid && (dataI[1].ctl.branch || dataI[1].ctl.jump)
        |-> dataI[0].valid && dataI[0].is_slot)
    else begin
        fail_count++;
        $error("FAIL %0t: branch at %h issued without its delay slot", $time, dataI[1].pc);
    end

endmodule

// ==== issue_queue.sv ====
`timescale 1ns/10ps
`include "issue_params.svh"

module issue_queue
    import issue_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  decode_data_t dataD [1:0],
    input  logic [1:0]   issue_en,
    input  logic         stall,
    input  logic         flush,
    output decode_data_t cand1,
    output decode_data_t cand2,
    output logic         que_empty,
    output logic         overflow,
    output bypass_req_t  req [1:0]
);

    typedef logic [`ISSUE_QUEUE_WIDTH-1:0] index_t;

    decode_data_t que [`ISSUE_QUEUE_SIZE];
    index_t       head;
    index_t       tail;
    index_t       count;

    // decode entries that issue straight away this cycle
    logic [1:0] taken;
    logic [1:0] enq;
    logic [1:0] n_pop;
    logic [1:0] n_push;
    logic       accept;

    // entries in use, never more than 31 thanks to overflow
    assign count     = tail - head;
    assign que_empty = (count == '0);
    assign overflow  = (count > index_t'(`ISSUE_QUEUE_SIZE - 3));

    // the two oldest instructions, queue first then decode
    always_comb begin
        if (que_empty) begin
            cand1 = dataD[1];
            cand2 = dataD[0];
        end else if (count == index_t'(1)) begin
            cand1 = que[head];
            cand2 = dataD[1];
        end else begin
            cand1 = que[head];
            cand2 = que[head + index_t'(1)];
        end
    end

    always_comb begin
        req[1].ra1 = cand1.ra1;
        req[1].ra2 = cand1.ra2;
        req[0].ra1 = cand2.ra1;
        req[0].ra2 = cand2.ra2;
    end

    // split issue between queued entries and decode entries
    always_comb begin
        taken = '0;
        n_pop = '0;
        if (que_empty) begin
            taken = issue_en;
        end else if (count == index_t'(1)) begin
            taken[1] = issue_en[0];
            n_pop    = {1'b0, issue_en[1]};
        end else begin
            n_pop = {1'b0, issue_en[1]} + {1'b0, issue_en[0]};
        end
        // head holds while stalled
        if (stall) begin
            n_pop = '0;
        end
    end

    // decode must hold its pair while overflow is up
    assign accept = ~overflow & ~flush;

    always_comb begin
        enq[1] = accept & dataD[1].valid & ~taken[1];
        enq[0] = accept & dataD[0].valid & ~taken[0];
        n_push = {1'b0, enq[1]} + {1'b0, enq[0]};
    end

    // older entry goes first, younger right behind it
    always_ff @(posedge clk) begin
        if (enq[1]) begin
            que[tail] <= dataD[1];
        end
        if (enq[0]) begin
            que[tail + index_t'(enq[1])] <= dataD[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            // drop everything still waiting
            head <= '0;
            tail <= '0;
        end else begin
            head <= head + index_t'(n_pop);
            tail <= tail + index_t'(n_push);
        end
    end

endmodule

// ==== issue_top.sv ====
`timescale 1ns/10ps

module issue_top
    import issue_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  decode_data_t dataD [1:0],
    input  wb_port_t     wb [1:0],
    input  logic         stall,
    input  logic         flush,
    output issue_data_t  dataI [1:0],
    output logic         overflow
);

    decode_data_t cand1;
    decode_data_t cand2;
    bypass_req_t  req [1:0];
    reg_addr_t    rf_ra [3:0];
    word_t        rf_data [3:0];
    bypass_out_t  opnd [3:0];
    logic [1:0]   issue_en;
    logic         have_slot;
    logic         hold;

    function automatic issue_data_t to_issue(decode_data_t d, logic v, word_t a, word_t b);
        issue_data_t o;
        o           = '0;
        o.valid     = v;
        o.pc        = d.pc;
        o.raw_instr = d.raw_instr;
        o.imm       = d.imm;
        o.rdst      = d.rdst;
        o.ctl       = d.ctl;
        o.rd1       = a;
        o.rd2       = b;
        return o;
    endfunction

    // nothing issues in the flush cycle
    assign hold = stall | flush;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rf_ra[2*i]   = req[i].ra1;
            rf_ra[2*i+1] = req[i].ra2;
        end
    end

    issue_queue u_queue (
        .clk       (clk),
        .reset     (reset),
        .dataD     (dataD),
        .issue_en  (issue_en),
        .stall     (stall),
        .flush     (flush),
        .cand1     (cand1),
        .cand2     (cand2),
        .que_empty (),
        .overflow  (overflow),
        .req       (req)
    );

    pair_check u_pair (
        .cand1     (cand1),
        .cand2     (cand2),
        .opnd      (opnd),
        .stall     (hold),
        .issue_en  (issue_en),
        .have_slot (have_slot)
    );

    operand_bypass u_bypass (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .req     (req),
        .rf_data (rf_data),
        .wb      (wb),
        .issued  (dataI),
        .opnd    (opnd)
    );

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .wb    (wb),
        .ra    (rf_ra),
        .rd    (rf_data)
    );

    always_comb begin
        dataI[1] = '0;
        dataI[0] = '0;
        if (issue_en[1]) begin
            dataI[1] = to_issue(cand1, cand1.valid, opnd[2].data, opnd[3].data);
        end
        if (issue_en[0]) begin
            dataI[0]         = to_issue(cand2, cand2.valid, opnd[0].data, opnd[1].data);
            dataI[0].is_slot = have_slot;
        end
    end

endmodule

// ==== operand_bypass.sv ====
`timescale 1ns/10ps
`include "issue_params.svh"

module operand_bypass
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  bypass_req_t req [1:0],
    input  word_t       rf_data [3:0],
    input  wb_port_t    wb [1:0],
    input  issue_data_t issued [1:0],
    output bypass_out_t opnd [3:0]
);

    // pending destination per register
    logic [`NUM_REGS-1:0] busy;
    logic [`NUM_REGS-1:0] busy_next;
    reg_addr_t            ra [3:0];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ra[2*i]   = req[i].ra1;
            ra[2*i+1] = req[i].ra2;
        end
    end

    // writeback this cycle beats the register file, port 1 first
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            opnd[k].ready  = 1'b1;
            opnd[k].bypass = 1'b0;
            opnd[k].data   = rf_data[k];
            if (ra[k] != '0) begin
                if (wb[1].valid && wb[1].rdst == ra[k]) begin
                    opnd[k].bypass = 1'b1;
                    opnd[k].data   = wb[1].data;
                end else if (wb[0].valid && wb[0].rdst == ra[k]) begin
                    opnd[k].bypass = 1'b1;
                    opnd[k].data   = wb[0].data;
                end else if (busy[ra[k]]) begin
                    opnd[k].ready = 1'b0;
                end
            end
        end
    end

    // a new writer wins over a writeback to the same register
    always_comb begin
        busy_next = busy;
        for (int p = 0; p < 2; p++) begin
            if (wb[p].valid) begin
                busy_next[wb[p].rdst] = 1'b0;
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (issued[p].valid && issued[p].ctl.regwrite) begin
                busy_next[issued[p].rdst] = 1'b1;
            end
        end
        busy_next[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

endmodule

// ==== pair_check.sv ====
`timescale 1ns/10ps

module pair_check
    import issue_pkg::*;
(
    input  decode_data_t cand1,
    input  decode_data_t cand2,
    input  bypass_out_t  opnd [3:0],
    input  logic         stall,
    output logic [1:0]   issue_en,
    output logic         have_slot
);

    logic ready1;
    logic ready0;
    logic bj1;
    logic raw_hazard;
    logic both_muldiv;
    logic hilo_hazard;
    logic block0;
    logic pair_ok;

    function automatic logic is_muldiv(op_t op);
        return op inside {MULT, MULTU, DIV, DIVU};
    endfunction

    // operands 3,2 belong to slot 1, operands 1,0 to slot 0
    assign ready1 = cand1.valid & opnd[2].ready & opnd[3].ready & ~stall;
    assign ready0 = cand2.valid & opnd[0].ready & opnd[1].ready;

    assign bj1 = cand1.ctl.branch | cand1.ctl.jump;

    // a delay slot may read the branch's destination
    assign raw_hazard = cand1.ctl.regwrite & ~bj1
                      & ((cand1.rdst == cand2.ra1) | (cand1.rdst == cand2.ra2));

    assign both_muldiv = is_muldiv(cand1.ctl.op) & is_muldiv(cand2.ctl.op);

    assign hilo_hazard = (cand1.ctl.hiwrite & cand2.ctl.hitoreg)
                       | (cand1.ctl.lowrite & cand2.ctl.lotoreg);

    assign block0 = raw_hazard
                  | both_muldiv
                  | hilo_hazard
                  | cand2.ctl.branch
                  | cand2.ctl.jump
                  | cand1.ctl.exception;

    assign pair_ok = ready0 & ~block0;

    // branch or jump waits until its delay slot can go too
    always_comb begin
        issue_en[1] = ready1 & (~bj1 | pair_ok);
        issue_en[0] = issue_en[1] & pair_ok;
    end

    assign have_slot = bj1 & issue_en[1];

endmodule

// ==== regfile.sv ====
`timescale 1ns/10ps
`include "issue_params.svh"

module regfile
    import issue_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  wb_port_t  wb [1:0],
    input  reg_addr_t ra [3:0],
    output word_t     rd [3:0]
);

    word_t regs [`NUM_REGS];

    // start from a known all-zero state
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // port 1 written last, so it wins on a clash
            for (int p = 0; p < 2; p++) begin
                if (wb[p].valid && wb[p].rdst != '0) begin
                    regs[wb[p].rdst] <= wb[p].data;
                end
            end
        end
    end

    // asynchronous reads, r0 hard-wired
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (ra[k] == '0) begin
                rd[k] = '0;
            end else begin
                rd[k] = regs[ra[k]];
            end
        end
    end

endmodule

// ==== sim.f ====
+incdir+.
issue_pkg.sv
issue_queue.sv
pair_check.sv
operand_bypass.sv
regfile.sv
issue_top.sv
tb_clock_gen.sv
issue_properties.sv
tb_issue.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // released just after a rising edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== tb_issue.sv ====
`timescale 1ns/10ps
`include "issue_params.svh"

module tb_issue
    import issue_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_PROGS       = 6;
    localparam int PROG_LEN        = 48;
    localparam int CYCLES_PER_PROG = 400;

    logic         clk;
    logic         reset;
    decode_data_t dataD [1:0];
    wb_port_t     wb [1:0];
    logic         stall;
    logic         flush;
    issue_data_t  dataI [1:0];
    logic         overflow;

    decode_data_t prog [PROG_LEN];
    word_t        shadow [`NUM_REGS];
    logic         pend [`NUM_REGS];
    int           pend_due [`NUM_REGS];
    word_t        pend_val [`NUM_REGS];
    logic [31:0]  lcg_state;
    word_t        exp_pc;
    int           cyc;
    int           errors;
    int           inflight;
    int           issued_n;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) i_clk (
        .clk   (clk),
        .reset (reset)
    );

    issue_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .dataD    (dataD),
        .wb       (wb),
        .stall    (stall),
        .flush    (flush),
        .dataI    (dataI),
        .overflow (overflow)
    );

    bind issue_top issue_properties i_props (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .dataI    (dataI),
        .overflow (overflow)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] v;
        v = lcg_next();
        return int'(v[30:16]) % n;
    endfunction

    // what execute hands back for an instruction
    function automatic word_t result_of(word_t pc);
        return (pc * 32'h9E37_79B1) ^ {pc[15:0], pc[31:16]};
    endfunction

    task automatic report_mismatch(string what, word_t got, word_t exp);
        errors++;
        $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    // registers 0..6 only so hazards come often
    task automatic build_program(input int p);
        decode_data_t d;
        int           k;
        logic         prev_bj;
        prev_bj = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            d       = '0;
            d.valid = 1'b1;
            d.pc    = 32'h0040_0000 + 32'(p) * 32'h1000 + 32'(4 * i);
            d.imm   = lcg_next();
            k       = rand_below(16);
            // no branch in a delay slot or at the very end
            if (k >= 11 && k <= 13 && (prev_bj || i == PROG_LEN - 1)) begin
                k = 0;
            end
            case (k)
                7, 8: begin
                    d.ctl.op      = op_t'(int'(MULT) + rand_below(4));
                    d.ctl.hiwrite = 1'b1;
                    d.ctl.lowrite = 1'b1;
                    d.ra1         = reg_addr_t'(rand_below(7));
                    d.ra2         = reg_addr_t'(rand_below(7));
                end
                9, 10: begin
                    d.ctl.op       = (k == 9) ? MFHI : MFLO;
                    d.ctl.hitoreg  = (k == 9);
                    d.ctl.lotoreg  = (k == 10);
                    d.ctl.regwrite = 1'b1;
                    d.rdst         = reg_addr_t'(1 + rand_below(6));
                end
                11, 12: begin
                    d.ctl.op     = BRANCH;
                    d.ctl.branch = 1'b1;
                    d.ra1        = reg_addr_t'(rand_below(7));
                    d.ra2        = reg_addr_t'(rand_below(7));
                end
                13: begin
                    d.ctl.op   = JUMP;
                    d.ctl.jump = 1'b1;
                end
                14: begin
                    d.ctl.op        = SYSCALL;
                    d.ctl.exception = 1'b1;
                end
                default: begin
                    d.ctl.op       = ALU;
                    d.ctl.regwrite = 1'b1;
                    d.ra1          = reg_addr_t'(rand_below(7));
                    d.ra2          = reg_addr_t'(rand_below(7));
                    d.rdst         = reg_addr_t'(1 + rand_below(6));
                end
            endcase
            d.raw_instr = {2'b00, d.ctl.op, d.ra1, d.ra2, d.rdst, 11'(i)};
            prog[i]     = d;
            prev_bj     = d.ctl.branch | d.ctl.jump;
        end
    endtask

    task automatic drive_cycle(input logic f, input logic s, input int n, input int idx);
        int used;
        used = 0;
        @(posedge clk);
        #1;
        cyc++;
        flush    = f;
        stall    = s;
        dataD[1] = '0;
        dataD[0] = '0;
        if (n >= 1) begin
            dataD[1] = prog[idx];
        end
        if (n >= 2) begin
            dataD[0] = prog[idx + 1];
        end
        wb[1] = '0;
        wb[0] = '0;
        // results due now go out on two ports and the rest slip a cycle
        for (int r = 1; r < `NUM_REGS; r++) begin
            if (pend[r] && pend_due[r] <= cyc && used < 2) begin
                wb[used].valid = 1'b1;
                wb[used].rdst  = reg_addr_t'(r);
                wb[used].data  = pend_val[r];
                pend[r]        = 1'b0;
                used++;
            end
        end
    endtask

    task automatic check_issued(input issue_data_t d);
        reg_addr_t    s1;
        reg_addr_t    s2;
        decode_data_t e;
        logic         exp_slot;
        s1 = d.raw_instr[25:21];
        s2 = d.raw_instr[20:16];
        assert (d.pc == exp_pc) else report_mismatch("issued pc", d.pc, exp_pc);
        assert (d.rd1 == shadow[s1]) else report_mismatch("rd1", d.rd1, shadow[s1]);
        assert (d.rd2 == shadow[s2]) else report_mismatch("rd2", d.rd2, shadow[s2]);
        assert (!pend[s1] && !pend[s2]) else begin
            errors++;
            $display("FAIL %0t: pc %h issued before its source was written back",
                     $time, d.pc);
        end
        // payload must match the program entry at this position
        if (issued_n < PROG_LEN) begin
            e        = prog[issued_n];
            exp_slot = issued_n > 0
                    && (prog[issued_n - 1].ctl.branch || prog[issued_n - 1].ctl.jump);
            assert (d.raw_instr == e.raw_instr) else begin
                report_mismatch("raw_instr", d.raw_instr, e.raw_instr);
            end
            assert (d.imm == e.imm) else report_mismatch("imm", d.imm, e.imm);
            assert (d.rdst == e.rdst && d.ctl == e.ctl) else begin
                report_mismatch("rdst and ctl", word_t'({d.rdst, d.ctl}),
                                word_t'({e.rdst, e.ctl}));
            end
            assert (d.is_slot == exp_slot) else begin
                report_mismatch("is_slot", word_t'(d.is_slot), word_t'(exp_slot));
            end
        end
        exp_pc = d.pc + 32'd4;
        issued_n++;
        // a younger writer makes the older result dead
        if (d.ctl.regwrite && d.rdst != '0) begin
            pend[d.rdst]     = 1'b1;
            pend_due[d.rdst] = cyc + 2 + rand_below(4);
            pend_val[d.rdst] = result_of(d.pc);
        end
    endtask

    task automatic sample_cycle(input int n, output logic accepted);
        int   n_issued;
        logic full;
        n_issued = 0;
        @(negedge clk);
        for (int p = 0; p < 2; p++) begin
            if (wb[p].valid) begin
                shadow[wb[p].rdst] = wb[p].data;
            end
        end
        full = (inflight >= `ISSUE_QUEUE_SIZE - 2);
        assert (overflow == full) else begin
            report_mismatch("overflow", word_t'(overflow), word_t'(full));
        end
        accepted = !overflow && !flush;
        for (int s = 1; s >= 0; s--) begin
            if (dataI[s].valid) begin
                check_issued(dataI[s]);
                n_issued++;
            end
        end
        inflight = inflight + (accepted ? n : 0) - n_issued;
        if (flush) begin
            inflight = 0;
        end
    endtask

    task automatic run_program(input int p);
        int   idx;
        int   n;
        int   t;
        int   burst;
        logic accepted;
        logic held;
        logic stall_now;
        logic early_flush;
        build_program(p);
        // flush drops leftovers and execute drops its results too
        for (int r = 0; r < `NUM_REGS; r++) begin
            pend[r] = 1'b0;
        end
        drive_cycle(1'b1, 1'b0, 0, 0);
        sample_cycle(0, accepted);
        exp_pc      = prog[0].pc;
        issued_n    = 0;
        idx         = 0;
        n           = 0;
        t           = 0;
        held        = 1'b0;
        burst       = 2 + rand_below(6);
        early_flush = (p % 3 == 1);
        while (issued_n < PROG_LEN) begin
            stall_now = (t >= burst && t < burst + 20) || rand_below(8) == 0;
            // decode keeps its pair while overflow is up
            if (!held) begin
                n = (t >= burst && t < burst + 20) ? 2 : rand_below(4);
                if (n > 2) begin
                    n = 2;
                end
                if (n > PROG_LEN - idx) begin
                    n = PROG_LEN - idx;
                end
            end
            drive_cycle(1'b0, stall_now, n, idx);
            sample_cycle(n, accepted);
            held = !accepted && n > 0;
            if (accepted) begin
                idx += n;
            end
            t++;
            if (early_flush && idx == PROG_LEN) begin
                break;
            end
        end
    endtask

    initial begin
        int props_failed;
        lcg_state = 32'd32;
        errors    = 0;
        inflight  = 0;
        issued_n  = 0;
        cyc       = 0;
        exp_pc    = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        dataD[1]  = '0;
        dataD[0]  = '0;
        wb[1]     = '0;
        wb[0]     = '0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            shadow[r]   = '0;
            pend[r]     = 1'b0;
            pend_due[r] = 0;
            pend_val[r] = '0;
        end
        @(negedge reset);
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        drive_cycle(1'b0, 1'b0, 0, 0);
        drive_cycle(1'b0, 1'b0, 0, 0);
        @(negedge clk);
        props_failed = i_dut.i_props.fail_count;
        $display("errors: %0d in data checks, %0d in bound assertions", errors, props_failed);
        if (errors == 0 && props_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // budget of cycles per program plus reset and slack
    initial begin
        #(CLK_PERIOD * (CYCLES_PER_PROG * NUM_PROGS + 20));
        $display("run timed out before all programs finished issuing");
        $display("TEST FAILED");
        $finish;
    end

endmodule
